// File: Makefile
SRCS := $(shell cat files.f)

.PHONY: run clean

run: obj_dir/Vgb_sys_tb
	obj_dir/Vgb_sys_tb | tee sim.log
	grep -qx "All checks passed" sim.log

obj_dir/Vgb_sys_tb: files.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ns \
		--top-module gb_sys_tb -f files.f -o Vgb_sys_tb

clean:
	rm -rf obj_dir sim.log

// File: files.f
source/gb_bus_pkg.sv
source/gb_ram.sv
source/gb_int_ctrl.sv
source/gb_timer.sv
source/gb_oam_dma.sv
source/gb_bus_hub.sv
source/gb_sys_top.sv
tests/gb_sys_properties.sv
tests/gb_sys_tb.sv

// File: source/gb_bus_hub.sv
`timescale 1ns/1ns

module gb_bus_hub
    import gb_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    // APB slave
    input  logic [15:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  pwdata,
    output logic [7:0]  prdata,
    output logic        pready,
    // DMA master
    input  logic        dma_active,
    input  logic [15:0] dma_addr,
    input  logic        dma_rd,
    // Block read data
    input  logic [7:0]  hram_rdata,
    input  logic [7:0]  wram_rdata,
    input  logic [7:0]  oam_rdata,
    input  logic [7:0]  ie_rdata,
    input  logic [7:0]  if_rdata,
    input  logic [7:0]  timer_rdata,
    input  logic [7:0]  dma_rdata,
    // Shared bus and strobes
    output logic [15:0] bus_addr,
    output logic [7:0]  bus_wdata,
    output logic        hram_we,
    output logic        wram_we,
    output logic        oam_we,
    output logic        ie_wr,
    output logic        if_wr,
    output logic        timer_wr,
    output logic        dma_reg_wr,
    output logic [7:0]  dma_src_rdata,
    // Cartridge
    output logic [15:0] cart_a,
    output logic [7:0]  cart_dout,
    input  logic [7:0]  cart_din,
    output logic        cart_rd,
    output logic        cart_wr,
    output logic        cart_cs
);

    logic [3:0] rgn_p;   // Region of the APB address
    logic [3:0] rgn_b;   // Region of the bus address
    logic       dma_q;   // DMA active last cycle
    logic       stall;
    logic       wr_go;
    logic       rd_go;

    // Console address map, highest priority first
    function automatic logic [3:0] region_of(input logic [15:0] a);
        logic [3:0] r;
        if (a == ADDR_IE) r = RGN_IE;
        else if (a >= HRAM_BASE) r = RGN_HRAM;
        else if (a == ADDR_IF) r = RGN_IF;
        else if (a == ADDR_DIV || a == ADDR_TIMA || a == ADDR_TMA || a == ADDR_TAC)
            r = RGN_TIMER;
        else if (a == ADDR_DMA) r = RGN_DMA;
        else if (a >= OAM_BASE && a <= OAM_LAST) r = RGN_OAM;
        else if (a >= IO_BASE && a <= IO_LAST) r = RGN_IO;
        else if (a >= WRAM_BASE && a <= WRAM_LAST) r = RGN_WRAM;
        else r = RGN_CART;
        return r;
    endfunction

    function automatic logic [7:0] read_mux(input logic [3:0] rgn);
        case (rgn)
            RGN_IE:    return ie_rdata;
            RGN_HRAM:  return hram_rdata;
            RGN_IF:    return if_rdata;
            RGN_TIMER: return timer_rdata;
            RGN_DMA:   return dma_rdata;
            RGN_OAM:   return oam_rdata;
            RGN_IO:    return 8'hFF; // Nothing behind it
            RGN_WRAM:  return wram_rdata;
            default:   return cart_din;
        endcase
    endfunction

    ////////////////////////////////
    // Master select and handshake
    ////////////////////////////////
    assign bus_addr  = dma_active ? dma_addr : paddr; // DMA owns all but HRAM
    assign bus_wdata = pwdata;
    assign rgn_p     = region_of(paddr);
    assign rgn_b     = region_of(bus_addr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            dma_q <= 1'b0;
        else
            dma_q <= dma_active;
    end

    // Extra cycle after DMA so RAM sees paddr before pready
    assign stall  = (dma_active | dma_q) & (rgn_p != RGN_HRAM);
    assign pready = psel & penable & ~stall;
    assign wr_go  = pready & pwrite;
    assign rd_go  = pready & ~pwrite;

    always_comb prdata = read_mux(rgn_p);
    always_comb dma_src_rdata = read_mux(rgn_b); // Source byte for DMA

    // Single-cycle write strobes
    always_comb begin
        hram_we    = 1'b0;
        wram_we    = 1'b0;
        oam_we     = 1'b0;
        ie_wr      = 1'b0;
        if_wr      = 1'b0;
        timer_wr   = 1'b0;
        dma_reg_wr = 1'b0;
        cart_wr    = 1'b0;
        if (wr_go) begin
            case (rgn_p)
                RGN_IE:    ie_wr = 1'b1;
                RGN_HRAM:  hram_we = 1'b1;
                RGN_IF:    if_wr = 1'b1;
                RGN_TIMER: timer_wr = 1'b1;
                RGN_DMA:   dma_reg_wr = 1'b1;
                RGN_OAM:   oam_we = 1'b1;
                RGN_WRAM:  wram_we = 1'b1;
                RGN_CART:  cart_wr = 1'b1;
                default:   cart_wr = 1'b0; // Unmapped I/O drops it
            endcase
        end
    end

    ////////////////////////////////
    // Cartridge port
    ////////////////////////////////
    assign cart_a    = bus_addr; // Address always visible
    assign cart_rd   = (rd_go & (rgn_p == RGN_CART)) | (dma_rd & (rgn_b == RGN_CART));
    assign cart_dout = cart_wr ? bus_wdata : 8'h00;
    assign cart_cs   = cart_rd | cart_wr;

endmodule

// File: source/gb_bus_pkg.sv
package gb_bus_pkg;

    ////////////////////////////////
    // Register addresses
    ////////////////////////////////
    localparam logic [15:0] ADDR_IE   = 16'hFFFF; // Interrupt enable
    localparam logic [15:0] ADDR_IF   = 16'hFF0F; // Interrupt flags
    localparam logic [15:0] ADDR_DIV  = 16'hFF04; // Divider upper byte
    localparam logic [15:0] ADDR_TIMA = 16'hFF05; // Timer counter
    localparam logic [15:0] ADDR_TMA  = 16'hFF06; // Timer modulo
    localparam logic [15:0] ADDR_TAC  = 16'hFF07; // Timer control
    localparam logic [15:0] ADDR_DMA  = 16'hFF46; // OAM DMA source page

    // Region bounds, inclusive
    localparam logic [15:0] HRAM_BASE = 16'hFF80; // Runs up to FFFE, FFFF is IE
    localparam logic [15:0] WRAM_BASE = 16'hC000;
    localparam logic [15:0] WRAM_LAST = 16'hDFFF;
    localparam logic [15:0] OAM_BASE  = 16'hFE00;
    localparam logic [15:0] OAM_LAST  = 16'hFE9F;
    localparam logic [15:0] IO_BASE   = 16'hFF00;
    localparam logic [15:0] IO_LAST   = 16'hFF7F;

    // Bit positions in IE / IF
    localparam logic [2:0] INT_VBLANK = 3'd0;
    localparam logic [2:0] INT_LCD    = 3'd1;
    localparam logic [2:0] INT_TIMER  = 3'd2;
    localparam logic [2:0] INT_SERIAL = 3'd3;
    localparam logic [2:0] INT_JOYPAD = 3'd4;

    // Timer prescaler terminal counts, period minus one (1024, 16, 64, 256)
    localparam logic [9:0] TIMER_DIV_SEL [0:3] = '{10'd1023, 10'd15, 10'd63, 10'd255};

    localparam logic [7:0] DMA_LEN = 8'd160; // Bytes per OAM transfer

    ////////////////////////////////
    // Decode regions, in priority order
    ////////////////////////////////
    localparam logic [3:0] RGN_IE    = 4'd0;
    localparam logic [3:0] RGN_HRAM  = 4'd1;
    localparam logic [3:0] RGN_IF    = 4'd2;
    localparam logic [3:0] RGN_TIMER = 4'd3;
    localparam logic [3:0] RGN_DMA   = 4'd4;
    localparam logic [3:0] RGN_OAM   = 4'd5;
    localparam logic [3:0] RGN_IO    = 4'd6; // Unmapped I/O
    localparam logic [3:0] RGN_WRAM  = 4'd7;
    localparam logic [3:0] RGN_CART  = 4'd8; // Everything else

endpackage

// File: source/gb_int_ctrl.sv
`timescale 1ns/1ns

module gb_int_ctrl
    import gb_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ie_wr,
    input  logic       if_wr,
    input  logic [7:0] wdata,
    input  logic       timer_req,
    output logic [7:0] ie_rdata,
    output logic [7:0] if_rdata,
    output logic [4:0] int_pending
);

    logic [4:0] int_en;   // IE
    logic [4:0] int_flag; // IF
    logic [4:0] req;      // Single-cycle requests from peripherals

    // Only the timer is present as a source
    always_comb begin
        req             = 5'b00000;
        req[INT_VBLANK] = 1'b0;
        req[INT_LCD]    = 1'b0;
        req[INT_TIMER]  = timer_req;
        req[INT_SERIAL] = 1'b0;
        req[INT_JOYPAD] = 1'b0;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            int_en   <= 5'b00000;
            int_flag <= 5'b00000;
        end else begin
            if (ie_wr)
                int_en <= wdata[4:0];
            // A request landing on a flag write still sticks
            if (if_wr)
                int_flag <= wdata[4:0] | req;
            else
                int_flag <= int_flag | req;
        end
    end

    assign ie_rdata    = {3'b000, int_en};   // Upper bits read 0
    assign if_rdata    = {3'b111, int_flag}; // Upper bits read 1
    assign int_pending = int_en & int_flag;

endmodule

// File: source/gb_oam_dma.sv
`timescale 1ns/1ns

module gb_oam_dma
    import gb_bus_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        reg_wr,    // Write to FF46
    input  logic [7:0]  wdata,
    output logic [7:0]  rdata,
    input  logic [7:0]  bus_rdata, // Source byte from the hub
    output logic        dma_active,
    output logic [15:0] dma_addr,
    output logic        dma_rd,
    output logic        dma_oam_wr,
    output logic [7:0]  dma_wdata,
    output logic [7:0]  oam_index
);

    logic [7:0] src_page;
    logic [7:0] index;    // Byte n of the transfer
    logic       wr_phase; // 0 read source, 1 write OAM

    ////////////////////////////////
    // Copy sequencer
    ////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_page   <= 8'h00;
            index      <= 8'h00;
            wr_phase   <= 1'b0;
            dma_active <= 1'b0;
        end else if (reg_wr) begin
            src_page   <= wdata; // Latch page and start
            index      <= 8'h00;
            wr_phase   <= 1'b0;
            dma_active <= 1'b1;
        end else if (dma_active) begin
            wr_phase <= ~wr_phase;
            if (wr_phase) begin
                // Last OAM write ends the transfer
                if (index == DMA_LEN - 8'd1)
                    dma_active <= 1'b0;
                else
                    index <= index + 8'd1;
            end
        end
    end

    // Address held over both cycles of a byte
    assign dma_addr   = {src_page, index};
    assign dma_rd     = dma_active & ~wr_phase;
    assign dma_oam_wr = dma_active & wr_phase;
    assign dma_wdata  = bus_rdata; // RAM data lands in the write cycle
    assign oam_index  = index;
    assign rdata      = src_page;

endmodule

// File: source/gb_ram.sv
`timescale 1ns/1ns

// Byte-wide single-port RAM, registered read
module gb_ram #(
    parameter int WORDS = 128
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(WORDS)-1:0] addr,
    input  logic [7:0]               din,
    output logic [7:0]               dout
);

    logic [7:0] mem [WORDS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
        end
        dout <= mem[addr]; // Old contents on a same-cycle write
    end

endmodule

// File: source/gb_sys_top.sv
`timescale 1ns/1ns

module gb_sys_top (
    input  logic        clk,
    input  logic        rst,
    // APB slave
    input  logic [15:0] paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  pwdata,
    output logic [7:0]  prdata,
    output logic        pready,
    // Cartridge bus
    output logic [15:0] cart_a,
    output logic [7:0]  cart_dout,
    input  logic [7:0]  cart_din,
    output logic        cart_rd,
    output logic        cart_wr,
    output logic        cart_cs,
    output logic [4:0]  int_pending
);

    logic [15:0] bus_addr;
    logic [7:0]  bus_wdata;
    logic        hram_we, wram_we, oam_we;
    logic        ie_wr, if_wr, timer_wr, dma_reg_wr;
    logic [7:0]  hram_rdata, wram_rdata, oam_rdata;
    logic [7:0]  ie_rdata, if_rdata, timer_rdata, dma_rdata;
    logic [7:0]  dma_src_rdata;
    logic        timer_req;
    // DMA master side
    logic        dma_active, dma_rd, dma_oam_wr;
    logic [15:0] dma_addr;
    logic [7:0]  dma_wdata, oam_index;
    // OAM port, DMA or hub
    logic        oam_we_sel;
    logic [7:0]  oam_addr_sel, oam_din_sel;

    gb_bus_hub hub_i (
        .clk, .rst,
        .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .dma_active, .dma_addr, .dma_rd,
        .hram_rdata, .wram_rdata, .oam_rdata,
        .ie_rdata, .if_rdata, .timer_rdata, .dma_rdata,
        .bus_addr, .bus_wdata,
        .hram_we, .wram_we, .oam_we, .ie_wr, .if_wr, .timer_wr, .dma_reg_wr,
        .dma_src_rdata,
        .cart_a, .cart_dout, .cart_din, .cart_rd, .cart_wr, .cart_cs
    );

    // HRAM hangs off the APB address, usable during DMA
    gb_ram #(.WORDS(128)) hram_i (
        .clk, .we(hram_we), .addr(paddr[6:0]), .din(bus_wdata), .dout(hram_rdata)
    );

    gb_ram #(.WORDS(8192)) wram_i (
        .clk, .we(wram_we), .addr(bus_addr[12:0]), .din(bus_wdata), .dout(wram_rdata)
    );

    assign oam_we_sel   = dma_active ? dma_oam_wr : oam_we;
    assign oam_addr_sel = dma_active ? oam_index : bus_addr[7:0];
    assign oam_din_sel  = dma_active ? dma_wdata : bus_wdata;

    gb_ram #(.WORDS(160)) oam_i (
        .clk, .we(oam_we_sel), .addr(oam_addr_sel), .din(oam_din_sel), .dout(oam_rdata)
    );

    gb_int_ctrl int_i (
        .clk, .rst, .ie_wr, .if_wr, .wdata(bus_wdata), .timer_req,
        .ie_rdata, .if_rdata, .int_pending
    );

    gb_timer timer_i (
        .clk, .rst, .wr(timer_wr), .reg_sel(bus_addr[1:0]), .wdata(bus_wdata),
        .rdata(timer_rdata), .timer_req
    );

    gb_oam_dma dma_i (
        .clk, .rst, .reg_wr(dma_reg_wr), .wdata(bus_wdata), .rdata(dma_rdata),
        .bus_rdata(dma_src_rdata), .dma_active, .dma_addr, .dma_rd, .dma_oam_wr,
        .dma_wdata, .oam_index
    );

endmodule

// File: source/gb_timer.sv
`timescale 1ns/1ns

module gb_timer
    import gb_bus_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       wr,
    input  logic [1:0] reg_sel, // 0 DIV, 1 TIMA, 2 TMA, 3 TAC
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic       timer_req
);

    logic [15:0] div_cnt;  // Free running, upper byte visible
    logic [7:0]  tima;
    logic [7:0]  tma;
    logic [2:0]  tac;      // Bit 2 enable, bits 1:0 rate
    logic [9:0]  prescale;
    logic        tick;

    // One tick per selected period while enabled
    assign tick = tac[2] && (prescale >= TIMER_DIV_SEL[tac[1:0]]);

    ////////////////////////////////
    // Divider and prescaler
    ////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt  <= 16'h0000;
            prescale <= 10'd0;
        end else begin
            if (wr && reg_sel == 2'd0)
                div_cnt <= 16'h0000; // Any DIV write clears it
            else
                div_cnt <= div_cnt + 16'd1;

            if (!tac[2] || tick)
                prescale <= 10'd0;
            else
                prescale <= prescale + 10'd1;
        end
    end

    ////////////////////////////////
    // Counter, modulo, control
    ////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tima      <= 8'h00;
            tma       <= 8'h00;
            tac       <= 3'b000;
            timer_req <= 1'b0;
        end else begin
            timer_req <= 1'b0; // Pulse only
            if (wr && reg_sel == 2'd1) begin
                tima <= wdata; // Bus write beats the tick
            end else if (tick) begin
                if (tima == 8'hFF) begin
                    tima      <= tma; // Reload on overflow
                    timer_req <= 1'b1;
                end else begin
                    tima <= tima + 8'd1;
                end
            end
            if (wr && reg_sel == 2'd2)
                tma <= wdata;
            if (wr && reg_sel == 2'd3)
                tac <= wdata[2:0];
        end
    end

    always_comb begin
        case (reg_sel)
            2'd0:    rdata = div_cnt[15:8];
            2'd1:    rdata = tima;
            2'd2:    rdata = tma;
            default: rdata = {5'b00000, tac};
        endcase
    end

endmodule

// File: tests/gb_sys_properties.sv
`timescale 1ns/1ns

// Protocol checks on the APB front and the OAM DMA engine
module gb_sys_properties (
    input logic        clk,
    input logic        rst,
    input logic [15:0] paddr,
    input logic        psel,
    input logic        penable,
    input logic        pready,
    input logic        cart_rd,
    input logic        cart_wr,
    input logic        dma_active
);

    ////////////////////////////////
    // APB handshake
    ////////////////////////////////
    // Address held until the transfer completes
    addr_stable: assert property (@(posedge clk) disable iff (rst)
        (psel && !pready) |=> $stable(paddr))
        else $error("paddr changed during an unfinished APB transfer");

    // Access cycle follows a setup or a stalled access
    pready_in_access: assert property (@(posedge clk) disable iff (rst)
        pready |-> (psel && penable && $past(psel))) // Never in setup or idle
        else $error("pready high outside an access cycle");

    ////////////////////////////////
    // Cartridge and DMA
    ////////////////////////////////
    cart_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(cart_rd && cart_wr))
        else $error("cart_rd and cart_wr high together");

    // 160 bytes at two cycles each
    dma_length: assert property (@(posedge clk) disable iff (rst)
        $rose(dma_active) |-> ##320 $fell(dma_active))
        else $error("dma_active did not fall 320 cycles after rising");

endmodule

bind gb_sys_top gb_sys_properties props_i (
    .clk, .rst, .paddr, .psel, .penable, .pready, .cart_rd, .cart_wr, .dma_active
);

// File: tests/gb_sys_tb.sv
`timescale 1ns/1ns

module gb_sys_tb
    import gb_bus_pkg::*;
();

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic [15:0] paddr = 16'h0000;
    logic        psel = 1'b0;
    logic        penable = 1'b0;
    logic        pwrite = 1'b0;
    logic [7:0]  pwdata = 8'h00;
    logic [7:0]  prdata;
    logic        pready;
    logic [15:0] cart_a;
    logic [7:0]  cart_dout;
    logic [7:0]  cart_din;
    logic        cart_rd, cart_wr, cart_cs;
    logic [4:0]  int_pending;

    integer      seed = 89;
    int          errors = 0;
    int          checks = 0;
    int          err_start = 0;
    int          test_no = 0;

    // Snapshot of the access cycle that completed last
    logic [7:0]  cap_rdata;
    logic [15:0] cap_cart_a;
    logic [7:0]  cap_cart_dout;
    logic        cap_cart_cs, cap_cart_rd, cap_cart_wr, cap_dma_active;
    int          cap_waits;

    // Shadow image for the reference model
    logic [7:0]  shadow [65536];
    logic [4:0]  sh_ie = 5'b00000;
    logic [4:0]  sh_if = 5'b00000;

    event        rd_done; // One read handed to the comparer
    logic [15:0] rd_addr;
    logic [7:0]  rd_data;
    logic [7:0]  expected;

    gb_sys_top dut_i (
        .clk, .rst, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .cart_a, .cart_dout, .cart_din, .cart_rd, .cart_wr, .cart_cs, .int_pending
    );

    assign cart_din = cart_a[7:0] ^ cart_a[15:8]; // ROM stand-in

    initial begin
        forever #10 clk = ~clk;
    end

    ////////////////////////////////
    // Reference model
    ////////////////////////////////
    function automatic void model_write(input logic [15:0] a, input logic [7:0] d);
        shadow[a] = d;
        if (a == ADDR_IE)
            sh_ie = d[4:0];
        if (a == ADDR_IF)
            sh_if = d[4:0];
        if (a == ADDR_DMA) begin
            // OAM gets the whole source page
            for (int n = 0; n < int'(DMA_LEN); n++)
                shadow[16'(OAM_BASE + n)] = shadow[16'({d, 8'h00} + n)];
        end
    endfunction

    // Timer registers are not covered here
    function automatic logic [7:0] model_read(input logic [15:0] a);
        if (a == ADDR_IE)
            return {3'b000, sh_ie};
        if (a == ADDR_IF)
            return {3'b111, sh_if};
        if (a >= HRAM_BASE || a == ADDR_DMA)
            return shadow[a];
        if (a >= IO_BASE)
            return 8'hFF; // Open I/O
        if ((a >= WRAM_BASE && a <= WRAM_LAST) || (a >= OAM_BASE && a <= OAM_LAST))
            return shadow[a];
        return a[7:0] ^ a[15:8]; // Cartridge
    endfunction

    always @(rd_done) begin
        expected = model_read(rd_addr);
        checks++;
        if (rd_data !== expected) begin
            $display("[FAIL] prdata @%h: got %h, expected %h", rd_addr, rd_data, expected);
            errors++;
        end
    end

    ////////////////////////////////
    // APB master
    ////////////////////////////////
    task automatic apb_xfer(input logic [15:0] a, input logic wr, input logic [7:0] d);
        int n;
        @(posedge clk);
        paddr   <= a;
        pwrite  <= wr;
        pwdata  <= d;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1; // Access phase
        n = 0;
        @(negedge clk);
        while (!pready && n < 1000) begin
            @(negedge clk);
            n++;
        end
        if (!pready) begin
            $display("Timeout: no pready for the transfer at %h", a);
            $display("Checks failed");
            $finish;
        end else begin
            cap_rdata      = prdata;
            cap_cart_a     = cart_a;
            cap_cart_dout  = cart_dout;
            cap_cart_cs    = cart_cs;
            cap_cart_rd    = cart_rd;
            cap_cart_wr    = cart_wr;
            cap_dma_active = dut_i.dma_active;
            cap_waits      = n;
            @(posedge clk); // Transfer taken here
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic write_byte(input logic [15:0] a, input logic [7:0] d);
        model_write(a, d);
        apb_xfer(a, 1'b1, d);
    endtask

    task automatic read_byte(input logic [15:0] a);
        apb_xfer(a, 1'b0, 8'h00);
        rd_addr = a;
        rd_data = cap_rdata;
        -> rd_done;
    endtask

    task automatic expect_eq(input string name, input logic [15:0] got, input logic [15:0] exp);
        checks++;
        if (got !== exp) begin
            $display("[FAIL] %s: got %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        @(posedge clk); // Comparer catches up
        test_no++;
        $display("Test %0d %s: %0d errors", test_no, name, errors - err_start);
        err_start = errors;
    endtask

    ////////////////////////////////
    // Test sequence
    ////////////////////////////////
    initial begin
        logic [31:0] r;
        logic [15:0] a;
        logic [15:0] addrs [64];
        logic [15:0] cart_addrs [5];
        int          n;
        cart_addrs = '{16'h0150, 16'h4A3C, 16'hA123, 16'hE010, 16'hFEA5};
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // 1. Random RAM traffic over WRAM, HRAM, OAM
        for (int i = 0; i < 64; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'd1:    a = {9'h1FF, r[14:8]};
                2'd2:    a = OAM_BASE | {8'h00, r[15:8] % 8'd160};
                default: a = {3'b110, r[20:8]};
            endcase
            if (a == ADDR_IE)
                a = 16'hFFFE; // Keep off IE
            addrs[i] = a;
            r = $random(seed);
            write_byte(a, r[7:0]);
        end
        for (int i = 0; i < 64; i++)
            read_byte(addrs[i]);
        end_test("RAM write/read");

        // 2. Cartridge and open I/O
        for (int i = 0; i < 5; i++) begin
            read_byte(cart_addrs[i]);
            expect_eq("cart_a", cap_cart_a, cart_addrs[i]);
            expect_eq("cart_cs", 16'(cap_cart_cs), 16'h0001);
            expect_eq("cart_rd", 16'(cap_cart_rd), 16'h0001);
        end
        write_byte(16'h2000, 8'h5A);
        expect_eq("cart_a", cap_cart_a, 16'h2000);
        expect_eq("cart_dout", 16'(cap_cart_dout), 16'h005A);
        expect_eq("cart_wr", 16'(cap_cart_wr), 16'h0001);
        expect_eq("cart_cs", 16'(cap_cart_cs), 16'h0001);
        read_byte(16'hFF01);
        read_byte(16'hFF40);
        read_byte(16'hFF7F);
        end_test("cartridge and I/O");

        // 3. IE / IF and the pending mask
        write_byte(ADDR_IE, 8'hF5);
        write_byte(ADDR_IF, 8'h0B);
        read_byte(ADDR_IE);
        read_byte(ADDR_IF);
        @(negedge clk);
        expect_eq("int_pending", 16'(int_pending), 16'(sh_ie & sh_if));
        write_byte(ADDR_IE, 8'h1F);
        write_byte(ADDR_IF, 8'h16);
        @(negedge clk);
        expect_eq("int_pending", 16'(int_pending), 16'(sh_ie & sh_if));
        write_byte(ADDR_IE, 8'h00);
        write_byte(ADDR_IF, 8'h00);
        end_test("interrupt registers");

        // 4. Timer overflow at the 16-cycle rate
        write_byte(ADDR_TMA, 8'hFE);
        write_byte(ADDR_TIMA, 8'hFF);
        write_byte(ADDR_TAC, 8'h05);
        repeat (20) @(posedge clk);
        apb_xfer(ADDR_TIMA, 1'b0, 8'h00);
        checks++;
        if (cap_rdata < 8'hFE) begin
            $display("[FAIL] TIMA: got %h, expected FE or more", cap_rdata);
            errors++;
        end
        apb_xfer(ADDR_IF, 1'b0, 8'h00);
        expect_eq("IF timer bit", 16'(cap_rdata[INT_TIMER]), 16'h0001);
        write_byte(ADDR_IE, 8'h04);
        n = 0;
        while (!int_pending[INT_TIMER] && n < 50) begin
            @(negedge clk);
            n++;
        end
        checks++;
        if (!int_pending[INT_TIMER]) begin
            $display("Timer interrupt never reached int_pending bit 2");
            errors++;
        end
        write_byte(ADDR_DIV, 8'h55);
        apb_xfer(ADDR_DIV, 1'b0, 8'h00);
        expect_eq("DIV", 16'(cap_rdata), 16'h0000);
        write_byte(ADDR_TAC, 8'h00); // Stop ticking
        end_test("timer");

        // 5. OAM DMA from page C1
        for (int i = 0; i < 160; i++) begin
            r = $random(seed);
            write_byte(16'(16'hC100 + i), r[7:0]);
        end
        write_byte(ADDR_DMA, 8'hC1);
        write_byte(16'hFF90, 8'h3C); // HRAM stays open
        expect_eq("dma_active", 16'(cap_dma_active), 16'h0001);
        read_byte(16'hFF90);
        expect_eq("dma_active", 16'(cap_dma_active), 16'h0001);
        read_byte(16'hC105); // Held off until the copy ends
        expect_eq("dma_active", 16'(cap_dma_active), 16'h0000);
        checks++;
        if (cap_waits == 0) begin
            $display("Work RAM read during DMA was not held back");
            errors++;
        end
        for (int i = 0; i < 160; i++)
            read_byte(16'(OAM_BASE + i));
        read_byte(ADDR_DMA);
        end_test("OAM DMA");

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule
